// ==== rtl/mm_bus_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_bus_slave import mm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] address,
    input  logic              read,
    input  logic              write,
    input  row_t              writedata,
    output logic [BUS_DW-1:0] readdata,
    output logic              in_we,
    output logic              wt_we,
    output logic [1:0]        buf_row,
    output row_t              buf_data,
    output logic              start,
    input  logic              busy,
    input  logic              done,
    output logic              res_rd_en,
    output logic [3:0]        res_rd_addr,
    input  acc_t              res_rd_data
);

    mm_region_e  region;
    logic        ctrl_hit;     // offset 0 of the control region is the only live register
    logic [31:0] status_word;

    assign region   = mm_region_e'(address[9:8]);
    assign ctrl_hit = (region == REG_CTRL) && (address[7:0] == 8'd0);

    // operand rows are frozen while a run is in flight so the sequencer sees stable data
    assign in_we    = write && (region == REG_INPUT) && !busy;
    assign wt_we    = write && (region == REG_WEIGHT) && !busy;
    assign buf_row  = address[1:0];  // one word per row, four rows per buffer
    assign buf_data = writedata;

    // bit 0 of the written word is element 0 bit 0, the start request
    assign start = write && ctrl_hit && writedata[0][0]; // the sequencer drops it when busy

    assign res_rd_en   = read && (region == REG_RESULT);
    assign res_rd_addr = address[3:0];

    assign status_word = {30'd0, done, busy};

    // one cycle read latency for every region, the word holds between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            readdata <= '0;
        end else if (read) begin
            unique case (region)
                REG_CTRL: begin
                    readdata <= ctrl_hit ? status_word : '0;
                end
                REG_RESULT: begin
                    readdata <= res_rd_data; // arbiter serves this read combinationally
                end
                default: begin
                    readdata <= '0;          // operand buffers are write only
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mm_mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_mac_array import mm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,   // start of a new output row
    input  logic     acc_en,  // one term of the dot product this cycle
    input  elem_t    a_elem,  // scalar shared by all lanes
    input  row_t     b_row,   // lane j takes element j
    output acc_row_t acc
);

    logic signed [2*ELEM_W-1:0] prod [N];

    // signed 8 by 8 products never overflow 16 bits
    always_comb begin
        for (int j = 0; j < N; j++) begin
            prod[j] = a_elem * b_row[j];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (acc_en) begin
            for (int j = 0; j < N; j++) begin
                if (clear) begin
                    acc[j] <= acc_t'(prod[j]);          // sign extended, first term of the row
                end else begin
                    acc[j] <= acc[j] + acc_t'(prod[j]); // wraps at 32 bits
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mm_operand_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

// small register file holding one operand matrix, one packed row per entry
module mm_operand_buf import mm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [1:0] wr_row,
    input  row_t       wr_data,
    input  logic [1:0] rd_row,
    output row_t       rd_data
);

    row_t rows [N];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < N; r++) begin
                rows[r] <= '0; // an unloaded matrix reads as all zero
            end
        end else if (we) begin
            rows[wr_row] <= wr_data;
        end
    end

    // the sequencer uses the row in the same cycle it selects it
    assign rd_data = rows[rd_row];

endmodule

`default_nettype wire

// ==== rtl/mm_pkg.sv ====
`default_nettype none

package mm_pkg;

    localparam int N      = 4;  // matrix dimension, rows and columns
    localparam int ELEM_W = 8;  // one signed operand element
    localparam int ACC_W  = 32; // accumulator and result word
    localparam int BUS_DW = 32; // one bus word carries one full row of N elements
    localparam int ADDR_W = 10; // region lives in the top two address bits

    typedef logic signed [ELEM_W-1:0] elem_t;

    // element j sits in bits 8j+7 to 8j, so a bus word maps straight onto a row
    typedef elem_t [N-1:0] row_t;

    typedef logic signed [ACC_W-1:0] acc_t;
    typedef acc_t [N-1:0] acc_row_t;

    // address bits 9:8 select one of these regions
    typedef enum logic [1:0] {
        REG_CTRL   = 2'b00, // start bit on write, status word on read
        REG_INPUT  = 2'b01, // A matrix rows
        REG_WEIGHT = 2'b10, // B matrix rows
        REG_RESULT = 2'b11  // sixteen result words, row major
    } mm_region_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAC,
        S_STORE
    } seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/mm_result_arb.sv ====
`timescale 1ns/100ps
`default_nettype none

// result memory shared by host reads and sequencer writes, host reads always win
module mm_result_arb import mm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_en,
    input  logic [3:0] rd_addr,
    output acc_t       rd_data,
    mm_wr_if.slave     wr
);

    acc_t mem [N*N];

    // a bus read in this cycle stalls the sequencer for one cycle
    assign wr.gnt = wr.req && !rd_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < N*N; e++) begin
                mem[e] <= '0; // results read as zero until the first run finishes
            end
        end else if (wr.gnt) begin
            mem[wr.addr] <= wr.wdata;
        end
    end

    // the bus slave registers this, which gives the one cycle read latency
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// ==== rtl/mm_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_seq import mm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    output logic       busy,
    output logic       done,
    output logic [1:0] a_row_sel,
    output logic [1:0] b_row_sel,
    input  row_t       a_row,
    input  row_t       b_row,
    output logic       clear,
    output logic       acc_en,
    output elem_t      a_elem,
    output row_t       b_out,
    input  acc_row_t   acc,
    mm_wr_if.master    wr
);

    seq_state_e state;
    logic [1:0] row_i;  // output row being built
    logic [1:0] term_k; // dot product term, also the B row index
    logic [1:0] col;    // accumulator lane being stored

    assign busy = (state != S_IDLE);

    // C[i] is the sum over k of A[i][k] times B row k, one term per cycle
    assign a_row_sel = row_i;
    assign b_row_sel = term_k;
    assign a_elem    = a_row[term_k];
    assign b_out     = b_row;
    assign acc_en    = (state == S_MAC);
    assign clear     = (term_k == 2'd0); // only acts together with acc_en

    assign wr.req   = (state == S_STORE);
    assign wr.addr  = {row_i, col};      // row times 4 plus column
    assign wr.wdata = acc[col];          // stable until the grant moves col on

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            row_i  <= '0;
            term_k <= '0;
            col    <= '0;
            done   <= 1'b0;
        end else begin
            unique case (state)
                S_IDLE: begin
                    if (start) begin
                        state  <= S_MAC;
                        row_i  <= '0;
                        term_k <= '0;
                        done   <= 1'b0; // done clears only on an accepted start
                    end
                end
                S_MAC: begin
                    term_k <= term_k + 2'd1;
                    if (term_k == 2'(N-1)) begin
                        state <= S_STORE; // last term lands in acc at this edge
                        col   <= '0;
                    end
                end
                S_STORE: begin
                    if (wr.gnt) begin
                        col <= col + 2'd1;
                        if (col == 2'(N-1)) begin
                            if (row_i == 2'(N-1)) begin
                                state <= S_IDLE;
                                done  <= 1'b1; // same edge that drops busy
                            end else begin
                                state  <= S_MAC;
                                row_i  <= row_i + 2'd1;
                                term_k <= '0;
                            end
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mm_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_top import mm_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [9:0]  address,
    input  logic        read,
    input  logic        write,
    input  row_t        writedata,
    output logic [31:0] readdata
);

    logic       in_we, wt_we, start, busy, done, res_rd_en, clear, acc_en;
    logic [1:0] buf_row, a_row_sel, b_row_sel;
    logic [3:0] res_rd_addr;
    row_t       buf_data, a_row, b_row, b_out;
    acc_t       res_rd_data;
    elem_t      a_elem;
    acc_row_t   acc;

    mm_wr_if wr_if_i ();

    mm_bus_slave bus_slave_i (
        .clk, .rst, .address, .read, .write, .writedata, .readdata,
        .in_we, .wt_we, .buf_row, .buf_data, .start, .busy, .done,
        .res_rd_en, .res_rd_addr, .res_rd_data
    );

    // A matrix, the input
    mm_operand_buf in_buf_i (
        .clk, .rst, .we(in_we), .wr_row(buf_row), .wr_data(buf_data),
        .rd_row(a_row_sel), .rd_data(a_row)
    );

    // B matrix, the weights
    mm_operand_buf wt_buf_i (
        .clk, .rst, .we(wt_we), .wr_row(buf_row), .wr_data(buf_data),
        .rd_row(b_row_sel), .rd_data(b_row)
    );

    mm_mac_array mac_i (
        .clk, .rst, .clear, .acc_en, .a_elem, .b_row(b_out), .acc
    );

    mm_seq seq_i (
        .clk, .rst, .start, .busy, .done, .a_row_sel, .b_row_sel, .a_row, .b_row,
        .clear, .acc_en, .a_elem, .b_out, .acc, .wr(wr_if_i.master)
    );

    mm_result_arb res_arb_i (
        .clk, .rst, .rd_en(res_rd_en), .rd_addr(res_rd_addr), .rd_data(res_rd_data),
        .wr(wr_if_i.slave)
    );

endmodule

`default_nettype wire

// ==== rtl/mm_wr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// result write path from the sequencer into the shared result memory
interface mm_wr_if import mm_pkg::*; ();

    logic       req;   // held high with addr and wdata until gnt is seen
    logic       gnt;   // write happens in the cycle where req and gnt are both high
    logic [3:0] addr;  // row times 4 plus column
    acc_t       wdata;

    modport master (output req, output addr, output wdata, input gnt);

    modport slave (input req, input addr, input wdata, output gnt);

endinterface

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the matrix multiply testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mm -f src.f -o tb_mm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q 'All tests passed!'; then
    exit 0
fi
exit 1

// ==== src.f ====
rtl/mm_pkg.sv
rtl/mm_wr_if.sv
rtl/mm_bus_slave.sv
rtl/mm_operand_buf.sv
rtl/mm_mac_array.sv
rtl/mm_seq.sv
rtl/mm_result_arb.sv
rtl/mm_top.sv
test/tb_mm.sv

// ==== test/tb_mm.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mm import mm_pkg::*; ();

    localparam int RUNS       = 10;  // full matrix runs over all the tests
    localparam int POLL_LIMIT = 200; // status reads allowed before giving up on done
    localparam int WATCHDOG   = RUNS * N * N * N * 200 + 2000; // cycles, margin included

    logic        clk, rst, read, write;
    logic [9:0]  address;
    row_t        writedata;
    logic [31:0] readdata;

    row_t   a_m [N];          // host copy of the input matrix
    row_t   b_m [N];          // host copy of the weight matrix
    acc_t   exp_c [N*N];      // expected results, row major
    acc_t   prev_exp [N*N];   // results of the run before the current one
    integer seed;
    int     value_errors, status_errors, timeout_errors;

    mm_top dut_i (.clk, .rst, .address, .read, .write, .writedata, .readdata);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every bus task starts and ends on a falling edge
    task automatic bus_write(input mm_region_e region, input logic [7:0] offset, input row_t data);
        address   = {region, offset};
        writedata = data;
        write     = 1'b1;
        @(negedge clk);
        write     = 1'b0;
    endtask

    task automatic bus_read(input mm_region_e region, input logic [7:0] offset,
                            output logic [31:0] data);
        address = {region, offset};
        read    = 1'b1;
        @(negedge clk);                 // the rising edge in between registers readdata
        read    = 1'b0;
        data    = readdata;
    endtask

    task automatic check_acc(input acc_t got, input acc_t exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s done,busy got %b expected %b", $time, what, got, exp);
            status_errors++;
        end
    endtask

    // C[i][j] is the sum over k of A[i][k] times B[k][j], wrapping at 32 bits
    task automatic compute_expected();
        acc_t sum;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = '0;
                for (int k = 0; k < N; k++) begin
                    sum = sum + acc_t'(a_m[i][k]) * acc_t'(b_m[k][j]);
                end
                exp_c[i*N+j] = sum;
            end
        end
    endtask

    task automatic load_matrices();
        for (int r = 0; r < N; r++) begin
            bus_write(REG_INPUT, 8'(r), a_m[r]);
            bus_write(REG_WEIGHT, 8'(r), b_m[r]);
        end
    endtask

    task automatic start_run();
        bus_write(REG_CTRL, 8'd0, row_t'(32'd1)); // bit 0 is the start request
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < POLL_LIMIT) begin
            bus_read(REG_CTRL, 8'd0, st);
            polls++;
        end
        if (!st[1]) begin
            $display("done never came up after %0d status reads", polls);
            timeout_errors++;
        end
    endtask

    task automatic check_results();
        logic [31:0] d;
        for (int e = 0; e < N*N; e++) begin
            bus_read(REG_RESULT, 8'(e), d);
            check_acc(acc_t'(d), exp_c[e], $sformatf("result %0d", e));
        end
    endtask

    task automatic run_and_check();
        load_matrices();
        compute_expected();
        start_run();
        wait_done();
        check_results();
    endtask

    task automatic random_fill();
        for (int r = 0; r < N; r++) begin
            a_m[r] = row_t'($random(seed));
            b_m[r] = row_t'($random(seed));
        end
    endtask

    task automatic test_reset();
        logic [31:0] st;
        bus_read(REG_CTRL, 8'd0, st);
        check_status(st[1:0], 2'b00, "after reset");
    endtask

    task automatic test_identity();
        random_fill();
        for (int r = 0; r < N; r++) begin
            a_m[r]    = '0;
            a_m[r][r] = elem_t'(1);
        end
        load_matrices();
        start_run();
        wait_done();
        for (int e = 0; e < N*N; e++) begin
            exp_c[e] = acc_t'(b_m[e/N][e%N]); // identity just copies B, sign extended
        end
        check_results();
    endtask

    task automatic test_random();
        for (int r = 0; r < N; r++) begin
            a_m[r] = {N{elem_t'(-128)}}; // largest positive product on every term
            b_m[r] = {N{elem_t'(-128)}};
        end
        run_and_check();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_m[i][j] = ((i + j) % 2 == 1) ? elem_t'(127) : elem_t'(-128);
                b_m[i][j] = ((i + j) % 2 == 1) ? elem_t'(-128) : elem_t'(127);
            end
        end
        run_and_check();
        random_fill();
        run_and_check();
    endtask

    task automatic test_status();
        logic [31:0] st;
        random_fill();
        load_matrices();
        compute_expected();
        start_run();
        bus_read(REG_CTRL, 8'd0, st);
        check_status(st[1:0], 2'b01, "first run in flight");
        wait_done();
        bus_read(REG_CTRL, 8'd0, st);
        check_status(st[1:0], 2'b10, "first run finished");
        start_run();                  // second start has to drop done again
        bus_read(REG_CTRL, 8'd0, st);
        check_status(st[1:0], 2'b01, "second run in flight");
        wait_done();
        bus_read(REG_CTRL, 8'd0, st);
        check_status(st[1:0], 2'b10, "second run finished");
        check_results();
    endtask

    task automatic test_busy_writes();
        row_t a_new [N];
        random_fill();
        load_matrices();
        compute_expected();
        start_run();
        for (int r = 0; r < N; r++) begin
            a_new[r] = row_t'($random(seed));
            bus_write(REG_INPUT, 8'(r), a_new[r]); // dropped, the run is busy
        end
        wait_done();
        check_results();              // still the product of the old A
        a_m = a_new;
        run_and_check();              // idle writes land this time
    endtask

    task automatic test_arb_stall();
        logic [31:0] d;
        random_fill();
        run_and_check();              // these results stay in memory while the next run stalls
        prev_exp = exp_c;
        random_fill();
        load_matrices();
        compute_expected();
        start_run();
        for (int n = 0; n < 40; n++) begin
            bus_read(REG_RESULT, 8'(n % (N*N)), d); // read held high, no write gets a grant
            check_acc(acc_t'(d), prev_exp[n % (N*N)], "read during stall");
        end
        bus_read(REG_CTRL, 8'd0, d);
        check_status(d[1:0], 2'b01, "after read burst");
        wait_done();
        check_results();
    endtask

    initial begin
        rst       = 1'b1;
        read      = 1'b0;
        write     = 1'b0;
        address   = '0;
        writedata = '0;
        seed      = 32'haa31_ea02;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_identity();
        test_random();
        test_status();
        test_busy_writes();
        test_arb_stall();

        $display("errors: value %0d, status %0d, timeout %0d",
                 value_errors, status_errors, timeout_errors);
        if (value_errors + status_errors + timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ends a hung run, sized for 200 cycles per multiply
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
